//--- Bender.yml
package:
  name: ooo_backend

sources:
  # Packages first, then the design bottom up
  - src/ooo_cfg_pkg.sv
  - src/uop_pkg.sv
  - src/free_list.sv
  - src/rename_stage.sv
  - src/rob.sv
  - src/ooo_backend.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/rob_sva.sv
      - test/ooo_backend_tb.sv

//--- ooo_backend.f
src/ooo_cfg_pkg.sv
src/uop_pkg.sv
src/free_list.sv
src/rename_stage.sv
src/rob.sv
src/ooo_backend.sv
test/rob_sva.sv
test/ooo_backend_tb.sv

//--- src/free_list.sv
/*
 * Physical register free list with one free bit per register,
 * lowest-first allocation per lane, release and full rebuild
 */
`timescale 1ns/1ps
`default_nettype none

module free_list (
  input  wire logic                                                   clock,
  input  wire logic                                                   reset,
  input  wire logic [ooo_cfg_pkg::ALLOC_COUNT_SIZE-1:0]               alloc_count,
  output ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]     alloc_prf,
  output logic [ooo_cfg_pkg::FREE_COUNT_SIZE-1:0]                     free_count,
  input  wire logic [ooo_cfg_pkg::COMMIT_WIDTH-1:0]                   release_valid,
  input  wire ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0] release_prf,
  input  wire logic                                                   rebuild,
  input  wire logic [ooo_cfg_pkg::PRF_INT_SIZE-1:0]                   rebuild_used
);

  import ooo_cfg_pkg::*;

  logic [PRF_INT_SIZE-1:0] free_q;
  logic [PRF_INT_SIZE-1:0] free_next;

  // Offer the lowest free registers per lane in ascending order
  always_comb begin
    logic [PRF_INT_SIZE-1:0] search;
    logic                    found;
    search = free_q;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      alloc_prf[l] = '0;
      found        = 1'b0;
      for (int i = 0; i < PRF_INT_SIZE; i++) begin
        if (!found && search[i]) begin
          alloc_prf[l] = prf_index_t'(i);
          found        = 1'b1;
        end
      end
      // Hide this pick from the next lane
      search[alloc_prf[l]] = 1'b0;
    end
  end

  always_comb begin
    free_count = '0;
    for (int i = 0; i < PRF_INT_SIZE; i++) begin
      free_count = free_count + FREE_COUNT_SIZE'(free_q[i]);
    end
  end

  always_comb begin
    free_next = free_q;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      if (l < alloc_count) begin
        free_next[alloc_prf[l]] = 1'b0;
      end
    end
    for (int l = 0; l < COMMIT_WIDTH; l++) begin
      if (release_valid[l]) begin
        free_next[release_prf[l]] = 1'b1;
      end
    end
    if (rebuild) begin
      free_next = ~rebuild_used;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // Registers above the identity map start out free
      for (int i = 0; i < PRF_INT_SIZE; i++) begin
        free_q[i] <= (i >= ARF_INT_SIZE);
      end
    end else begin
      free_q <= free_next;
    end
  end

endmodule

`default_nettype wire

//--- src/ooo_backend.sv
/*
 * Back end top level with the rename stage feeding the re-order buffer
 */
`timescale 1ns/1ps
`default_nettype none

module ooo_backend (
  input  wire logic                                                 clock,
  input  wire logic                                                 reset,

  input  wire logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]                 in_valid,
  input  wire ooo_cfg_pkg::arf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0] in_rd,
  input  wire uop_pkg::br_type_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]    in_br_type,
  input  wire logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]                 in_pred_taken,
  output logic                                                      in_ready,

  output logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]                      disp_valid,
  output ooo_cfg_pkg::rob_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]   disp_rob_index,
  output ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]   disp_prf,
  output uop_pkg::br_type_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]         disp_br_type,

  input  wire logic [ooo_cfg_pkg::COMMIT_WIDTH-1:0]                 cmp_valid,
  input  wire ooo_cfg_pkg::rob_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0] cmp_rob_index,
  input  wire logic [ooo_cfg_pkg::COMMIT_WIDTH-1:0]                 cmp_br_taken,

  output logic                                                      recover,
  output ooo_cfg_pkg::rob_index_t                                   recover_rob_index,

  output logic [ooo_cfg_pkg::COMMIT_WIDTH-1:0]                      ret_valid,
  output ooo_cfg_pkg::arf_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0]   ret_rd,
  output ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0]   ret_prf,
  output ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0]   ret_prf_prev
);

  import ooo_cfg_pkg::*;
  import uop_pkg::*;

  // Rename to ROB allocation group
  logic [RENAME_WIDTH-1:0]       alloc_valid;
  arf_index_t [RENAME_WIDTH-1:0] alloc_rd;
  prf_index_t [RENAME_WIDTH-1:0] alloc_prf;
  prf_index_t [RENAME_WIDTH-1:0] alloc_prf_prev;
  br_type_t [RENAME_WIDTH-1:0]   alloc_br_type;
  logic [RENAME_WIDTH-1:0]       alloc_pred_taken;

  // ROB occupancy status back to rename
  logic allocatable;
  logic rob_empty;

  rename_stage rename_stage_i (
    .clock            (clock),
    .reset            (reset),
    .in_valid         (in_valid),
    .in_rd            (in_rd),
    .in_br_type       (in_br_type),
    .in_pred_taken    (in_pred_taken),
    .in_ready         (in_ready),
    .alloc_valid      (alloc_valid),
    .alloc_rd         (alloc_rd),
    .alloc_prf        (alloc_prf),
    .alloc_prf_prev   (alloc_prf_prev),
    .alloc_br_type    (alloc_br_type),
    .alloc_pred_taken (alloc_pred_taken),
    .allocatable      (allocatable),
    .rob_empty        (rob_empty),
    .recover          (recover),
    .ret_valid        (ret_valid),
    .ret_rd           (ret_rd),
    .ret_prf          (ret_prf),
    .ret_prf_prev     (ret_prf_prev)
  );

  rob rob_i (
    .clock             (clock),
    .reset             (reset),
    .alloc_valid       (alloc_valid),
    .alloc_rd          (alloc_rd),
    .alloc_prf         (alloc_prf),
    .alloc_prf_prev    (alloc_prf_prev),
    .alloc_br_type     (alloc_br_type),
    .alloc_pred_taken  (alloc_pred_taken),
    .disp_valid        (disp_valid),
    .disp_rob_index    (disp_rob_index),
    .disp_prf          (disp_prf),
    .disp_br_type      (disp_br_type),
    .cmp_valid         (cmp_valid),
    .cmp_rob_index     (cmp_rob_index),
    .cmp_br_taken      (cmp_br_taken),
    .recover           (recover),
    .recover_rob_index (recover_rob_index),
    .ret_valid         (ret_valid),
    .ret_rd            (ret_rd),
    .ret_prf           (ret_prf),
    .ret_prf_prev      (ret_prf_prev),
    .allocatable       (allocatable),
    .rob_empty         (rob_empty)
  );

endmodule

`default_nettype wire

//--- src/ooo_cfg_pkg.sv
/*
 * Back end sizing: ROB depth, rename and commit widths,
 * register file sizes, and the index types derived from them
 */
`default_nettype none

package ooo_cfg_pkg;

  // ROB geometry
  localparam int ROB_SIZE       = 8;
  localparam int ROB_INDEX_SIZE = 3;

  // Micro-ops per rename group, and completion / retire lanes
  localparam int RENAME_WIDTH = 2;
  localparam int COMMIT_WIDTH = 2;

  // Integer register files
  localparam int ARF_INT_SIZE = 16;
  localparam int PRF_INT_SIZE = 32;

  // Counter widths used by the free list
  localparam int ALLOC_COUNT_SIZE = $clog2(RENAME_WIDTH + 1);
  localparam int FREE_COUNT_SIZE  = $clog2(PRF_INT_SIZE + 1);

  typedef logic [ROB_INDEX_SIZE-1:0]       rob_index_t;
  typedef logic [$clog2(ARF_INT_SIZE)-1:0] arf_index_t;
  typedef logic [$clog2(PRF_INT_SIZE)-1:0] prf_index_t;

endpackage

`default_nettype wire

//--- src/rename_stage.sv
/*
 * Rename stage with speculative and committed map tables,
 * group acceptance gating and drain-and-restore recovery
 */
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
  input  wire logic                                                 clock,
  input  wire logic                                                 reset,

  input  wire logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]                 in_valid,
  input  wire ooo_cfg_pkg::arf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0] in_rd,
  input  wire uop_pkg::br_type_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]    in_br_type,
  input  wire logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]                 in_pred_taken,
  output logic                                                      in_ready,

  output logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]                      alloc_valid,
  output ooo_cfg_pkg::arf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]   alloc_rd,
  output ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]   alloc_prf,
  output ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]   alloc_prf_prev,
  output uop_pkg::br_type_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]         alloc_br_type,
  output logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]                      alloc_pred_taken,

  input  wire logic                                                 allocatable,
  input  wire logic                                                 rob_empty,
  input  wire logic                                                 recover,

  input  wire logic [ooo_cfg_pkg::COMMIT_WIDTH-1:0]                 ret_valid,
  input  wire ooo_cfg_pkg::arf_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0] ret_rd,
  input  wire ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0] ret_prf,
  input  wire ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0] ret_prf_prev
);

  import ooo_cfg_pkg::*;

  prf_index_t spec_map    [ARF_INT_SIZE];
  prf_index_t spec_next   [ARF_INT_SIZE];
  prf_index_t commit_map  [ARF_INT_SIZE];
  prf_index_t commit_next [ARF_INT_SIZE];

  logic                             draining;
  logic                             restore;
  logic [ALLOC_COUNT_SIZE-1:0]      alloc_count;
  logic [FREE_COUNT_SIZE-1:0]       free_count;
  prf_index_t [RENAME_WIDTH-1:0]    fl_prf;
  logic [PRF_INT_SIZE-1:0]          rebuild_used;

  // A mispredicting completion also blocks the group in its own cycle
  assign in_ready = !reset && !draining && !recover && allocatable &&
                    (free_count >= FREE_COUNT_SIZE'(RENAME_WIDTH));

  // Drain done once the ROB has emptied
  assign restore = draining && rob_empty;

  assign alloc_rd         = in_rd;
  assign alloc_br_type    = in_br_type;
  assign alloc_pred_taken = in_pred_taken;

  // Lanes in order so lane 1 sees lane 0's new mapping
  always_comb begin
    alloc_valid = in_valid & {RENAME_WIDTH{in_ready}};
    alloc_count = '0;
    spec_next   = spec_map;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      alloc_prf[l]      = fl_prf[l];
      alloc_prf_prev[l] = spec_next[in_rd[l]];
      if (alloc_valid[l]) begin
        spec_next[in_rd[l]] = fl_prf[l];
        alloc_count         = alloc_count + 1'b1;
      end
    end
  end

  always_comb begin
    commit_next = commit_map;
    for (int l = 0; l < COMMIT_WIDTH; l++) begin
      if (ret_valid[l]) begin
        commit_next[ret_rd[l]] = ret_prf[l];
      end
    end
  end

  // Registers still named by the committed map
  always_comb begin
    rebuild_used = '0;
    for (int r = 0; r < ARF_INT_SIZE; r++) begin
      rebuild_used[commit_map[r]] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < ARF_INT_SIZE; r++) begin
        spec_map[r]   <= prf_index_t'(r);
        commit_map[r] <= prf_index_t'(r);
      end
      draining <= 1'b0;
    end else begin
      commit_map <= commit_next;
      if (restore) begin
        spec_map <= commit_next;
      end else begin
        spec_map <= spec_next;
      end
      draining <= recover || (draining && !restore);
    end
  end

  free_list free_list_i (
    .clock         (clock),
    .reset         (reset),
    .alloc_count   (alloc_count),
    .alloc_prf     (fl_prf),
    .free_count    (free_count),
    .release_valid (ret_valid),
    .release_prf   (ret_prf_prev),
    .rebuild       (restore),
    .rebuild_used  (rebuild_used)
  );

endmodule

`default_nettype wire

//--- src/rob.sv
/*
 * Re-order buffer with circular entry array, completion marking,
 * oldest-mispredict squash, in-order retire and dispatch indexing
 */
`timescale 1ns/1ps
`default_nettype none

module rob (
  input  wire logic                                                 clock,
  input  wire logic                                                 reset,

  input  wire logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]                 alloc_valid,
  input  wire ooo_cfg_pkg::arf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0] alloc_rd,
  input  wire ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0] alloc_prf,
  input  wire ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0] alloc_prf_prev,
  input  wire uop_pkg::br_type_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]    alloc_br_type,
  input  wire logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]                 alloc_pred_taken,

  output logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]                      disp_valid,
  output ooo_cfg_pkg::rob_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]   disp_rob_index,
  output ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]   disp_prf,
  output uop_pkg::br_type_t [ooo_cfg_pkg::RENAME_WIDTH-1:0]         disp_br_type,

  input  wire logic [ooo_cfg_pkg::COMMIT_WIDTH-1:0]                 cmp_valid,
  input  wire ooo_cfg_pkg::rob_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0] cmp_rob_index,
  input  wire logic [ooo_cfg_pkg::COMMIT_WIDTH-1:0]                 cmp_br_taken,

  output logic                                                      recover,
  output ooo_cfg_pkg::rob_index_t                                   recover_rob_index,

  output logic [ooo_cfg_pkg::COMMIT_WIDTH-1:0]                      ret_valid,
  output ooo_cfg_pkg::arf_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0]   ret_rd,
  output ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0]   ret_prf,
  output ooo_cfg_pkg::prf_index_t [ooo_cfg_pkg::COMMIT_WIDTH-1:0]   ret_prf_prev,

  output logic                                                      allocatable,
  output logic                                                      rob_empty
);

  import ooo_cfg_pkg::*;
  import uop_pkg::*;

  // Entry payload
  arf_index_t ent_rd         [ROB_SIZE];
  prf_index_t ent_prf        [ROB_SIZE];
  prf_index_t ent_prf_prev   [ROB_SIZE];
  br_type_t   ent_br_type    [ROB_SIZE];
  logic       ent_pred_taken [ROB_SIZE];

  logic [ROB_SIZE-1:0]     ent_complete;
  logic [ROB_SIZE-1:0]     complete_next;
  rob_index_t              head;
  rob_index_t              head_next;
  logic [ROB_INDEX_SIZE:0] count;
  logic [ROB_INDEX_SIZE:0] count_next;

  assign rob_empty   = (count == '0);
  assign allocatable = (int'(count) <= ROB_SIZE - RENAME_WIDTH);

  always_comb begin
    rob_index_t              slot;
    rob_index_t              age;
    rob_index_t              best_age;
    logic [ROB_INDEX_SIZE:0] count_cut;
    logic [ROB_INDEX_SIZE:0] ret_count;
    logic                    stop;

    complete_next = ent_complete;
    for (int l = 0; l < COMMIT_WIDTH; l++) begin
      if (cmp_valid[l]) begin
        complete_next[cmp_rob_index[l]] = 1'b1;
      end
    end

    // Oldest mispredict relative to head wins
    recover           = 1'b0;
    recover_rob_index = '0;
    best_age          = '0;
    for (int l = 0; l < COMMIT_WIDTH; l++) begin
      age = cmp_rob_index[l] - head;
      if (cmp_valid[l] &&
          is_mispredict(ent_br_type[cmp_rob_index[l]],
                        ent_pred_taken[cmp_rob_index[l]], cmp_br_taken[l])) begin
        if (!recover || age < best_age) begin
          recover           = 1'b1;
          best_age          = age;
          recover_rob_index = cmp_rob_index[l];
        end
      end
    end
    // Keep the branch itself and drop all younger entries
    count_cut = recover ? ({1'b0, best_age} + 1'b1) : count;

    ret_valid    = '0;
    ret_rd       = '0;
    ret_prf      = '0;
    ret_prf_prev = '0;
    ret_count    = '0;
    stop         = 1'b0;
    for (int l = 0; l < COMMIT_WIDTH; l++) begin
      slot = head + rob_index_t'(l);
      if (!stop && (l < count_cut) && complete_next[slot]) begin
        ret_valid[l]    = 1'b1;
        ret_rd[l]       = ent_rd[slot];
        ret_prf[l]      = ent_prf[slot];
        ret_prf_prev[l] = ent_prf_prev[slot];
        ret_count       = ret_count + 1'b1;
      end else begin
        stop = 1'b1;
      end
    end
    head_next  = head + ret_count[ROB_INDEX_SIZE-1:0];
    count_next = count_cut - ret_count;

    // Append at the tail but never in a recover cycle
    disp_valid     = '0;
    disp_rob_index = '0;
    disp_prf       = '0;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      disp_br_type[l] = BR_X;
      if (alloc_valid[l] && !recover) begin
        slot                = head_next + count_next[ROB_INDEX_SIZE-1:0];
        disp_valid[l]       = 1'b1;
        disp_rob_index[l]   = slot;
        disp_prf[l]         = alloc_prf[l];
        disp_br_type[l]     = alloc_br_type[l];
        complete_next[slot] = 1'b0;
        count_next          = count_next + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head         <= '0;
      count        <= '0;
      ent_complete <= '0;
    end else begin
      head         <= head_next;
      count        <= count_next;
      ent_complete <= complete_next;
    end
  end

  always_ff @(posedge clock) begin
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      if (disp_valid[l]) begin
        ent_rd[disp_rob_index[l]]         <= alloc_rd[l];
        ent_prf[disp_rob_index[l]]        <= alloc_prf[l];
        ent_prf_prev[disp_rob_index[l]]   <= alloc_prf_prev[l];
        ent_br_type[disp_rob_index[l]]    <= alloc_br_type[l];
        ent_pred_taken[disp_rob_index[l]] <= alloc_pred_taken[l];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/uop_pkg.sv
/*
 * Micro-op field types: branch kind encoding and the
 * misprediction test applied at completion
 */
`default_nettype none

package uop_pkg;

  // Branch kind carried by every micro-op
  typedef enum logic [1:0] {
    BR_X    = 2'd0,
    BR_COND = 2'd1,
    BR_JUMP = 2'd2
  } br_type_t;

  // A branch whose resolved direction differs from the prediction
  function automatic logic is_mispredict(
    input br_type_t br_type,
    input logic     pred_taken,
    input logic     br_taken
  );
    return (br_type != BR_X) && (pred_taken != br_taken);
  endfunction

endpackage

`default_nettype wire

//--- test/ooo_backend_tb.sv
/*
 * Back end testbench with clock and reset, LFSR-driven front end and
 * execute units, reference model, compare tasks and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module ooo_backend_tb;

  import ooo_cfg_pkg::*;
  import uop_pkg::*;

  localparam int NUM_CYCLES   = 2000;
  localparam int DRAIN_CYCLES = 200;
  localparam int RESET_CYCLES = 3;
  // Two clock periods for every cycle the test may take
  localparam int TIMEOUT_NS   = (NUM_CYCLES + DRAIN_CYCLES + RESET_CYCLES) * 20;

  logic                          clock = 1'b0;
  logic                          reset;
  logic [RENAME_WIDTH-1:0]       in_valid;
  arf_index_t [RENAME_WIDTH-1:0] in_rd;
  br_type_t [RENAME_WIDTH-1:0]   in_br_type;
  logic [RENAME_WIDTH-1:0]       in_pred_taken;
  logic                          in_ready;
  logic [RENAME_WIDTH-1:0]       disp_valid;
  rob_index_t [RENAME_WIDTH-1:0] disp_rob_index;
  prf_index_t [RENAME_WIDTH-1:0] disp_prf;
  br_type_t [RENAME_WIDTH-1:0]   disp_br_type;
  logic [COMMIT_WIDTH-1:0]       cmp_valid;
  rob_index_t [COMMIT_WIDTH-1:0] cmp_rob_index;
  logic [COMMIT_WIDTH-1:0]       cmp_br_taken;
  logic                          recover;
  rob_index_t                    recover_rob_index;
  logic [COMMIT_WIDTH-1:0]       ret_valid;
  arf_index_t [COMMIT_WIDTH-1:0] ret_rd;
  prf_index_t [COMMIT_WIDTH-1:0] ret_prf;
  prf_index_t [COMMIT_WIDTH-1:0] ret_prf_prev;

  logic [31:0] lfsr_state = 32'hbd01dd93;

  // Reference model state with ROB queue, both maps, free vector and drain flag
  rob_index_t              m_head;
  int                      m_count;
  arf_index_t              q_rd   [ROB_SIZE];
  prf_index_t              q_prf  [ROB_SIZE];
  prf_index_t              q_prev [ROB_SIZE];
  br_type_t                q_br   [ROB_SIZE];
  logic                    q_pred [ROB_SIZE];
  logic                    q_done [ROB_SIZE];
  prf_index_t              spec_map   [ARF_INT_SIZE];
  prf_index_t              commit_map [ARF_INT_SIZE];
  logic [PRF_INT_SIZE-1:0] free_vec;
  logic                    draining;

  // Group the front end holds until it is accepted
  logic                    grp_pending;
  logic [RENAME_WIDTH-1:0] grp_valid;
  arf_index_t              grp_rd [RENAME_WIDTH];
  br_type_t                grp_br [RENAME_WIDTH];
  logic [RENAME_WIDTH-1:0] grp_pred;

  ooo_backend ooo_backend_i (.*);

  always #5 clock = ~clock;

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  function automatic prf_index_t lowest_free(input logic [PRF_INT_SIZE-1:0] vec);
    prf_index_t pick;
    pick = '0;
    for (int i = PRF_INT_SIZE - 1; i >= 0; i--) begin
      if (vec[i]) begin
        pick = prf_index_t'(i);
      end
    end
    return pick;
  endfunction

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch(name, 32'(got), 32'(exp));
    end
  endtask

  task automatic check_rob_index(input string name, input rob_index_t got,
                                 input rob_index_t exp);
    if (got !== exp) begin
      report_mismatch(name, 32'(got), 32'(exp));
    end
  endtask

  task automatic check_prf(input string name, input prf_index_t got, input prf_index_t exp);
    if (got !== exp) begin
      report_mismatch(name, 32'(got), 32'(exp));
    end
  endtask

  task automatic check_arf(input string name, input arf_index_t got, input arf_index_t exp);
    if (got !== exp) begin
      report_mismatch(name, 32'(got), 32'(exp));
    end
  endtask

  task automatic check_br_type(input string name, input br_type_t got, input br_type_t exp);
    if (got !== exp) begin
      report_mismatch(name, 32'(got), 32'(exp));
    end
  endtask

  task automatic reset_model();
    m_head      = '0;
    m_count     = 0;
    draining    = 1'b0;
    grp_pending = 1'b0;
    grp_valid   = '0;
    grp_pred    = '0;
    for (int r = 0; r < ARF_INT_SIZE; r++) begin
      spec_map[r]   = prf_index_t'(r);
      commit_map[r] = prf_index_t'(r);
    end
    for (int i = 0; i < ROB_SIZE; i++) begin
      q_done[i] = 1'b0;
    end
    for (int i = 0; i < PRF_INT_SIZE; i++) begin
      free_vec[i] = (i >= ARF_INT_SIZE);
    end
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      grp_rd[l] = '0;
      grp_br[l] = BR_X;
    end
  endtask

  task automatic make_group();
    int n;
    int kind;
    n           = 1 + rand_bits(1);
    grp_pending = 1'b1;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      grp_valid[l] = (l < n);
      grp_rd[l]    = arf_index_t'(rand_bits($bits(arf_index_t)));
      kind         = rand_bits(2);
      grp_br[l]    = (kind == 0) ? BR_COND : (kind == 1) ? BR_JUMP : BR_X;
      grp_pred[l]  = rand_bits(1);
    end
  endtask

  // Up to one completion per lane among live entries not yet complete
  task automatic drive_completions();
    rob_index_t open_slots[$];
    rob_index_t slot;
    int         k;
    logic       miss;
    for (int a = 0; a < m_count; a++) begin
      slot = m_head + rob_index_t'(a);
      if (!q_done[slot]) begin
        open_slots.push_back(slot);
      end
    end
    cmp_valid     = '0;
    cmp_rob_index = '0;
    cmp_br_taken  = '0;
    for (int l = 0; l < COMMIT_WIDTH; l++) begin
      if (open_slots.size() > 0 && rand_bits(1) != 0) begin
        k    = rand_bits(3) % open_slots.size();
        slot = open_slots[k];
        open_slots.delete(k);
        cmp_valid[l]     = 1'b1;
        cmp_rob_index[l] = slot;
        // About one branch in four goes against its prediction
        miss = (rand_bits(2) == 0);
        if (q_br[slot] != BR_X) begin
          cmp_br_taken[l] = q_pred[slot] ^ miss;
        end else begin
          cmp_br_taken[l] = rand_bits(1);
        end
      end
    end
  endtask

  // Compare this cycle's outputs and advance the model across the edge
  task automatic check_cycle();
    logic                    done_n [ROB_SIZE];
    prf_index_t              spec_n [ARF_INT_SIZE];
    logic [PRF_INT_SIZE-1:0] free_n;
    logic [PRF_INT_SIZE-1:0] avail;
    logic                    rec;
    logic                    ready;
    logic                    restore;
    logic                    stop;
    rob_index_t              rec_idx;
    rob_index_t              slot;
    rob_index_t              h_n;
    prf_index_t              pick;
    int                      best_age;
    int                      age;
    int                      cut;
    int                      n_ret;
    int                      c_n;

    done_n   = q_done;
    rec      = 1'b0;
    rec_idx  = '0;
    best_age = ROB_SIZE;
    for (int l = 0; l < COMMIT_WIDTH; l++) begin
      if (cmp_valid[l]) begin
        slot         = cmp_rob_index[l];
        done_n[slot] = 1'b1;
        age          = int'(rob_index_t'(slot - m_head));
        if (q_br[slot] != BR_X && q_pred[slot] != cmp_br_taken[l] && age < best_age) begin
          rec      = 1'b1;
          rec_idx  = slot;
          best_age = age;
        end
      end
    end
    check_bit("recover", recover, rec);
    if (rec) begin
      check_rob_index("recover_rob_index", recover_rob_index, rec_idx);
    end
    cut = rec ? best_age + 1 : m_count;

    // Retire from the head up to the first incomplete entry
    n_ret  = 0;
    stop   = 1'b0;
    free_n = free_vec;
    for (int l = 0; l < COMMIT_WIDTH; l++) begin
      slot = m_head + rob_index_t'(l);
      if (!stop && l < cut && done_n[slot]) begin
        check_bit($sformatf("ret_valid[%0d]", l), ret_valid[l], 1'b1);
        check_arf($sformatf("ret_rd[%0d]", l), ret_rd[l], q_rd[slot]);
        check_prf($sformatf("ret_prf[%0d]", l), ret_prf[l], q_prf[slot]);
        check_prf($sformatf("ret_prf_prev[%0d]", l), ret_prf_prev[l], q_prev[slot]);
        commit_map[q_rd[slot]] = q_prf[slot];
        free_n[q_prev[slot]]   = 1'b1;
        n_ret++;
      end else begin
        stop = 1'b1;
        check_bit($sformatf("ret_valid[%0d]", l), ret_valid[l], 1'b0);
      end
    end
    h_n = m_head + rob_index_t'(n_ret);
    c_n = cut - n_ret;

    ready = !draining && !rec && (m_count <= ROB_SIZE - RENAME_WIDTH) &&
            ($countones(free_vec) >= RENAME_WIDTH);
    check_bit("in_ready", in_ready, ready);

    // Lane 1 sees the mapping lane 0 has just made
    spec_n = spec_map;
    avail  = free_vec;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      if (ready && grp_pending && grp_valid[l]) begin
        slot        = h_n + rob_index_t'(c_n);
        pick        = lowest_free(avail);
        avail[pick] = 1'b0;
        check_bit($sformatf("disp_valid[%0d]", l), disp_valid[l], 1'b1);
        check_rob_index($sformatf("disp_rob_index[%0d]", l), disp_rob_index[l], slot);
        check_prf($sformatf("disp_prf[%0d]", l), disp_prf[l], pick);
        check_br_type($sformatf("disp_br_type[%0d]", l), disp_br_type[l], grp_br[l]);
        q_rd[slot]         = grp_rd[l];
        q_prf[slot]        = pick;
        q_prev[slot]       = spec_n[grp_rd[l]];
        q_br[slot]         = grp_br[l];
        q_pred[slot]       = grp_pred[l];
        done_n[slot]       = 1'b0;
        spec_n[grp_rd[l]]  = pick;
        free_n[pick]       = 1'b0;
        c_n++;
      end else begin
        check_bit($sformatf("disp_valid[%0d]", l), disp_valid[l], 1'b0);
      end
    end
    if (ready) begin
      grp_pending = 1'b0;
    end

    // Restart from the committed state once drained
    restore = draining && (m_count == 0);
    if (restore) begin
      spec_n = commit_map;
      free_n = '1;
      for (int r = 0; r < ARF_INT_SIZE; r++) begin
        free_n[commit_map[r]] = 1'b0;
      end
    end
    draining = rec || (draining && !restore);
    spec_map = spec_n;
    free_vec = free_n;
    q_done   = done_n;
    m_head   = h_n;
    m_count  = c_n;
  endtask

  task automatic run_cycle(input logic offer);
    @(posedge clock);
    #1;
    if (!grp_pending && offer && rand_bits(2) != 0) begin
      make_group();
    end
    in_valid = grp_pending ? grp_valid : '0;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      in_rd[l]         = grp_rd[l];
      in_br_type[l]    = grp_br[l];
      in_pred_taken[l] = grp_pred[l];
    end
    drive_completions();
    #4;
    check_cycle();
  endtask

  initial begin
    reset         = 1'b1;
    in_valid      = '0;
    in_rd         = '0;
    in_pred_taken = '0;
    cmp_valid     = '0;
    cmp_rob_index = '0;
    cmp_br_taken  = '0;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
      in_br_type[l] = BR_X;
    end
    reset_model();
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    // Rename stays closed while reset is held
    check_bit("in_ready", in_ready, 1'b0);
    reset = 1'b0;

    for (int c = 0; c < NUM_CYCLES; c++) begin
      run_cycle(1'b1);
    end
    // Keep completing without new groups until everything has left
    while (grp_pending || m_count != 0 || draining) begin
      run_cycle(1'b0);
    end
    @(posedge clock);
    #1;
    cmp_valid = '0;
    in_valid  = '0;
    #4;
    check_bit("rob_empty", ooo_backend_i.rob_i.rob_empty, 1'b1);
    check_bit("in_ready", in_ready, 1'b1);

    if (ooo_backend_i.rob_i.rob_sva_i.failures == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures in the ROB checks",
               ooo_backend_i.rob_i.rob_sva_i.failures);
      abort_run();
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the back end did not finish within %0d ns", TIMEOUT_NS);
    abort_run();
  end

  // A failed bound assertion ends the run at once
  initial begin
    wait (ooo_backend_i.rob_i.rob_sva_i.failures != 0);
    $display("An assertion in the ROB checks failed");
    abort_run();
  end

endmodule

`default_nettype wire

//--- test/rob_sva.sv
/*
 * Concurrent checks on ROB retire, dispatch and recover outputs,
 * and the bind that attaches them to rob
 */
`timescale 1ns/1ps
`default_nettype none

module rob_sva (
  input wire logic                                  clock,
  input wire logic                                  reset,
  input wire logic                                  recover,
  input wire logic [ooo_cfg_pkg::COMMIT_WIDTH-1:0]  ret_valid,
  input wire logic [ooo_cfg_pkg::RENAME_WIDTH-1:0]  disp_valid
);

  // Failed assertions so far
  int failures = 0;

  // Retire lanes fill from lane 0 with no gap
  ret_contiguous: assert property (
    @(posedge clock) disable iff (reset)
      ((ret_valid & (ret_valid + 1'b1)) == '0)
  ) else begin
    failures++;
    $error("retire lanes are not contiguous from lane 0");
  end

  recover_in_reset: assert property (
    @(posedge clock) reset |-> !recover
  ) else begin
    failures++;
    $error("recover is high during reset");
  end

  // Nothing enters the ROB while it squashes
  no_disp_on_recover: assert property (
    @(posedge clock) disable iff (reset)
      recover |-> (disp_valid == '0)
  ) else begin
    failures++;
    $error("micro-op dispatched in a recover cycle");
  end

endmodule

bind rob rob_sva rob_sva_i (
  .clock      (clock),
  .reset      (reset),
  .recover    (recover),
  .ret_valid  (ret_valid),
  .disp_valid (disp_valid)
);

`default_nettype wire
